//--- logic/apuPkg.sv
`default_nettype none

package apuPkg;

	// ########################################################################
	// Widths
	// ########################################################################

	localparam int levelBits = 8;

	typedef logic [levelBits-1:0] levelT;
	typedef logic [10:0] periodT;
	typedef logic [3:0] volumeT;
	typedef logic [1:0] dutyT;
	typedef logic [7:0] addrT;
	typedef logic [31:0] dataT;

	// ########################################################################
	// Register map
	// ########################################################################

	localparam addrT regPulse0 = 8'h00;
	localparam addrT regPulse1 = 8'h04;
	localparam addrT regMaster = 8'h08;
	localparam addrT regGpioOut = 8'h0C;
	localparam addrT regGpioDir = 8'h10;
	localparam addrT regGpioIn = 8'h14;
	localparam addrT regIrqStat = 8'h18;
	localparam addrT regIrqMask = 8'h1C;

	// Writable bits of the wide registers
	localparam dataT pulseMask = 32'h000F_37FF;
	localparam dataT masterMask = 32'h0000_010F;

	localparam logic [1:0] respOkay = 2'd0;
	localparam logic [1:0] respSlvErr = 2'd2;

	// ########################################################################
	// Audio constants
	// ########################################################################

	// Entry 0 is 12.5 %, entry 3 is the inverted 25 % pattern
	localparam logic [3:0][7:0] dutyTable = {
		8'b10011111,
		8'b01111000,
		8'b01100000,
		8'b01000000
	};

	// Periods below this are ultrasonic, channel is muted
	localparam periodT minPeriod = 11'd8;

	// (15 + 15) * 15 / 2
	localparam levelT maxLevel = 8'd225;

	typedef struct packed {
		periodT period;
		dutyT duty;
		volumeT volume;
	} pulseCfgT;

	typedef struct packed {
		logic awvalid;
		addrT awaddr;
		logic wvalid;
		dataT wdata;
		logic [3:0] wstrb;
		logic bready;
		logic arvalid;
		addrT araddr;
		logic rready;
	} axiReqT;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		dataT rdata;
		logic [1:0] rresp;
	} axiRspT;

	typedef enum logic [1:0] {
		idle,
		writeResp,
		readResp
	} busStateT;

endpackage

`default_nettype wire

//--- logic/apuBusRegs.sv
`timescale 1ns/10ps
`default_nettype none

module apuBusRegs
	import apuPkg::*;
(
	input wire clk,
	input wire arstN,
	input wire axiReqT axiReq,
	output axiRspT axiRsp,
	output pulseCfgT pulseCfg0,
	output pulseCfgT pulseCfg1,
	output volumeT masterVol,
	output logic audioEn,
	output logic [7:0] ioOut,
	output logic [7:0] ioDir,
	input wire [7:0] ioSync,
	input wire [7:0] ioRise,
	output logic irqN
);

	busStateT state;
	dataT pulseReg0, pulseReg1, masterReg;
	logic [7:0] irqStat, irqMask, irqClr;
	logic wrAccept, rdAccept, wrHit, rdHit;
	dataT rdMux, rdata;
	logic [1:0] bresp, rresp;

	// Byte-lane merge of a write into an existing register image
	function automatic dataT mergeStrb(dataT old, dataT data, logic [3:0] strb, dataT mask);
		dataT merged;
		merged = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				merged[8*b +: 8] = data[8*b +: 8];
		end
		return merged & mask;
	endfunction

	function automatic pulseCfgT toCfg(dataT r);
		pulseCfgT cfg;
		cfg.period = r[10:0];
		cfg.duty = r[13:12];
		cfg.volume = r[19:16];
		return cfg;
	endfunction

	// ########################################################################
	// Handshake
	// ########################################################################

	// Write wins when both channels request in the same cycle
	assign wrAccept = (state == idle) && axiReq.awvalid && axiReq.wvalid;
	assign rdAccept = (state == idle) && axiReq.arvalid && !wrAccept;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (wrAccept)
						state <= writeResp;
					else if (rdAccept)
						state <= readResp;
				end
				writeResp: if (axiReq.bready) state <= idle;
				readResp: if (axiReq.rready) state <= idle;
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			bresp <= respOkay;
			rdata <= '0;
			rresp <= respOkay;
		end else begin
			if (wrAccept)
				bresp <= wrHit ? respOkay : respSlvErr;
			if (rdAccept) begin
				rdata <= rdMux;
				rresp <= rdHit ? respOkay : respSlvErr;
			end
		end
	end

	always_comb begin
		axiRsp.awready = wrAccept;
		axiRsp.wready = wrAccept;
		axiRsp.bvalid = state == writeResp;
		axiRsp.bresp = bresp;
		axiRsp.arready = rdAccept;
		axiRsp.rvalid = state == readResp;
		axiRsp.rdata = rdata;
		axiRsp.rresp = rresp;
	end

	// ########################################################################
	// Address decode and register file
	// ########################################################################

	// GPIO input is read-only, so it is not a write target
	always_comb begin
		case (axiReq.awaddr)
			regPulse0, regPulse1, regMaster, regGpioOut, regGpioDir, regIrqStat, regIrqMask:
				wrHit = 1'b1;
			default:
				wrHit = 1'b0;
		endcase
	end

	always_comb begin
		rdHit = 1'b1;
		rdMux = '0;
		case (axiReq.araddr)
			regPulse0: rdMux = pulseReg0;
			regPulse1: rdMux = pulseReg1;
			regMaster: rdMux = masterReg;
			regGpioOut: rdMux = dataT'(ioOut);
			regGpioDir: rdMux = dataT'(ioDir);
			regGpioIn: rdMux = dataT'(ioSync);
			regIrqStat: rdMux = dataT'(irqStat);
			regIrqMask: rdMux = dataT'(irqMask);
			default: rdHit = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pulseReg0 <= '0;
			pulseReg1 <= '0;
			masterReg <= '0;
			ioOut <= '0;
			ioDir <= '0;
			irqMask <= '0;
		end else if (wrAccept) begin
			case (axiReq.awaddr)
				regPulse0:
					pulseReg0 <= mergeStrb(pulseReg0, axiReq.wdata, axiReq.wstrb, pulseMask);
				regPulse1:
					pulseReg1 <= mergeStrb(pulseReg1, axiReq.wdata, axiReq.wstrb, pulseMask);
				regMaster:
					masterReg <= mergeStrb(masterReg, axiReq.wdata, axiReq.wstrb, masterMask);
				regGpioOut: if (axiReq.wstrb[0]) ioOut <= axiReq.wdata[7:0];
				regGpioDir: if (axiReq.wstrb[0]) ioDir <= axiReq.wdata[7:0];
				regIrqMask: if (axiReq.wstrb[0]) irqMask <= axiReq.wdata[7:0];
				default: ;
			endcase
		end
	end

	// ########################################################################
	// Interrupts
	// ########################################################################

	assign irqClr = (wrAccept && axiReq.awaddr == regIrqStat && axiReq.wstrb[0]) ?
		axiReq.wdata[7:0] : 8'd0;

	// A new edge beats a simultaneous clear
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			irqStat <= '0;
		else
			irqStat <= (irqStat & ~irqClr) | ioRise;
	end

	assign irqN = ~|(irqStat & irqMask);

	assign pulseCfg0 = toCfg(pulseReg0);
	assign pulseCfg1 = toCfg(pulseReg1);
	assign masterVol = masterReg[3:0];
	assign audioEn = masterReg[8];

	bHold: assert property (@(posedge clk) disable iff (!arstN)
		axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid);

	oneOutstanding: assert property (@(posedge clk) disable iff (!arstN)
		!(axiRsp.bvalid && axiRsp.rvalid));

endmodule

`default_nettype wire

//--- logic/apuPulse.sv
`timescale 1ns/10ps
`default_nettype none

module apuPulse
	import apuPkg::*;
(
	input wire clk,
	input wire arstN,
	input wire pulseCfgT cfg,
	output volumeT chanLevel
);

	periodT timer;
	logic [2:0] step;
	logic [2:0] bitSel;
	logic reload;
	logic patternBit;
	logic audible;

	// ########################################################################
	// Period timer and step pointer
	// ########################################################################

	// Reload every period + 1 clocks
	assign reload = timer == '0;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			timer <= '0;
			step <= '0;
		end else if (reload) begin
			timer <= cfg.period;
			step <= step + 3'd1;
		end else begin
			timer <= timer - 11'd1;
		end
	end

	// ########################################################################
	// Duty sequencer output
	// ########################################################################

	// Pattern is played MSB first
	assign bitSel = 3'd7 - step;
	assign patternBit = dutyTable[cfg.duty][bitSel];
	assign audible = cfg.period >= minPeriod;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			chanLevel <= '0;
		else if (patternBit && audible)
			chanLevel <= cfg.volume;
		else
			chanLevel <= '0;
	end

endmodule

`default_nettype wire

//--- logic/apuMixer.sv
`timescale 1ns/10ps
`default_nettype none

module apuMixer
	import apuPkg::*;
(
	input wire clk,
	input wire arstN,
	input wire volumeT chan0,
	input wire volumeT chan1,
	input wire volumeT masterVol,
	input wire audioEn,
	output levelT level
);

	logic [4:0] chanSum;
	logic [8:0] scaled;
	levelT halved;

	// Up to 30 * 15 = 450 before halving
	assign chanSum = {1'b0, chan0} + {1'b0, chan1};
	assign scaled = chanSum * masterVol;
	assign halved = scaled[8:1];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			level <= '0;
		else if (audioEn)
			level <= halved;
		else
			level <= '0;
	end

	levelRange: assert property (@(posedge clk) disable iff (!arstN)
		level <= maxLevel);

endmodule

`default_nettype wire

//--- logic/apuPwm.sv
`timescale 1ns/10ps
`default_nettype none

module apuPwm
	import apuPkg::*;
#(
	parameter int N = levelBits
) (
	input wire clk,
	input wire arstN,
	input wire en,
	input wire [N-1:0] cmp,
	output logic q
);

	logic [N-1:0] cnt;
	logic [N-1:0] cmpLatched;
	logic [N-1:0] frameCmp;

	// ########################################################################
	// Frame counter
	// ########################################################################

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			cnt <= '0;
		else if (en)
			cnt <= cnt + 1'b1;
		else
			cnt <= '0;
	end

	// New compare value only at the frame start
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			cmpLatched <= '0;
		else if (cnt == '0)
			cmpLatched <= cmp;
	end

	assign frameCmp = (cnt == '0) ? cmp : cmpLatched;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			q <= 1'b0;
		else
			q <= en && (cnt < frameCmp);
	end

endmodule

`default_nettype wire

//--- logic/gpioPort.sv
`timescale 1ns/10ps
`default_nettype none

module gpioPort (
	input wire clk,
	input wire arstN,
	input wire [7:0] ioOut,
	input wire [7:0] ioDir,
	input wire [7:0] pinIn,
	output logic [7:0] pinOut,
	output logic [7:0] pinOe,
	output logic [7:0] ioSync,
	output logic [7:0] ioRise
);

	logic [7:0] syncMeta;
	logic [7:0] prevIn;

	// ########################################################################
	// Output drive
	// ########################################################################

	// A set direction bit enables the pin driver
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pinOut <= '0;
			pinOe <= '0;
		end else begin
			pinOut <= ioOut;
			pinOe <= ioDir;
		end
	end

	// ########################################################################
	// Input synchronizer and edge capture
	// ########################################################################

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			syncMeta <= '0;
			ioSync <= '0;
			prevIn <= '0;
			ioRise <= '0;
		end else begin
			syncMeta <= pinIn;
			ioSync <= syncMeta;
			prevIn <= ioSync;
			// Driven pins never report edges
			ioRise <= ioSync & ~prevIn & ~ioDir;
		end
	end

endmodule

`default_nettype wire

//--- logic/apuSystem.sv
`timescale 1ns/10ps
`default_nettype none

module apuSystem
	import apuPkg::*;
(
	input wire clk,
	input wire arstN,
	input wire axiReqT axiReq,
	output axiRspT axiRsp,
	input wire [7:0] pinIn,
	output logic [7:0] pinOut,
	output logic [7:0] pinOe,
	output logic irqN,
	output logic audio,
	output levelT led
);

	pulseCfgT pulseCfg0, pulseCfg1;
	volumeT masterVol;
	logic audioEn;
	logic [7:0] ioOut, ioDir, ioSync, ioRise;
	volumeT chanLevel0, chanLevel1;
	levelT level;

	apuBusRegs busRegs (
		.clk, .arstN,
		.axiReq, .axiRsp,
		.pulseCfg0, .pulseCfg1,
		.masterVol, .audioEn,
		.ioOut, .ioDir,
		.ioSync, .ioRise,
		.irqN
	);

	// Tone channels
	apuPulse pulse0 (.clk, .arstN, .cfg(pulseCfg0), .chanLevel(chanLevel0));
	apuPulse pulse1 (.clk, .arstN, .cfg(pulseCfg1), .chanLevel(chanLevel1));

	apuMixer mixer (
		.clk, .arstN,
		.chan0(chanLevel0), .chan1(chanLevel1),
		.masterVol, .audioEn,
		.level
	);

	// Audio pin
	apuPwm #(.N(levelBits)) pwm0 (.clk, .arstN, .en(1'b1), .cmp(level), .q(audio));

	gpioPort gpio (
		.clk, .arstN,
		.ioOut, .ioDir,
		.pinIn, .pinOut, .pinOe,
		.ioSync, .ioRise
	);

	assign led = level;

endmodule

`default_nettype wire

//--- testbench/apuChecker.sv
`timescale 1ns/10ps
`default_nettype none

module apuChecker
	import apuPkg::*;
(
	input wire clk,
	input wire levelT led,
	input wire audio,
	input wire [7:0] pinOut,
	input wire [7:0] pinOe,
	input wire irqN
);

	int errCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int testErrs = 0;
	int testChecks = 0;

	// ########################################################################
	// Compare primitives
	// ########################################################################

	task automatic checkEq(input string name, input dataT expVal, input dataT actVal);
		checkCount++;
		testChecks++;
		if (expVal !== actVal) begin
			errCount++;
			testErrs++;
			$display("ERR %s expected 0x%0h got 0x%0h", name, expVal, actVal);
		end
	endtask

	task automatic failText(input string msg);
		checkCount++;
		testChecks++;
		errCount++;
		testErrs++;
		$display("Error: %s", msg);
	endtask

	// ########################################################################
	// Port checks
	// ########################################################################

	task automatic checkPins(input logic [7:0] expOut, input logic [7:0] expOe);
		checkEq("pinOut", dataT'(expOut), dataT'(pinOut));
		checkEq("pinOe", dataT'(expOe), dataT'(pinOe));
	endtask

	// Line is low while any flag meets its mask bit
	task automatic checkIrq(input logic [7:0] stat, input logic [7:0] mask);
		checkEq("irqN", dataT'(~|(stat & mask)), dataT'(irqN));
	endtask

	// Channel amplitudes are already zero for silent channels
	task automatic checkLedSet(input int amp0, input int amp1, input int master);
		int l0;
		int l1;
		int l2;
		checkCount++;
		testChecks++;
		l0 = amp0 * master / 2;
		l1 = amp1 * master / 2;
		l2 = (amp0 + amp1) * master / 2;
		if (led != 0 && led != l0 && led != l1 && led != l2) begin
			errCount++;
			testErrs++;
			$display("ERR led expected one of 0x0 0x%0h 0x%0h 0x%0h got 0x%0h",
				l0, l1, l2, led);
		end
	endtask

	// One PWM frame, counted from a rising edge of audio
	task automatic measureFrame(input int expLevel, output bit valid);
		levelT ledStart;
		logic prev;
		bit found;
		int waitCnt;
		int highs;
		ledStart = led;
		found = 0;
		waitCnt = 0;
		highs = 0;
		@(negedge clk);
		prev = audio;
		while (!found && waitCnt < 600) begin
			@(negedge clk);
			found = !prev && audio;
			prev = audio;
			waitCnt++;
		end
		if (found) begin
			for (int i = 0; i < 256; i++) begin
				if (audio)
					highs++;
				@(negedge clk);
			end
		end
		valid = found && ledStart != 0 && led == ledStart;
		if (valid) begin
			checkEq("led", dataT'(expLevel), dataT'(ledStart));
			checkEq("audio high count", dataT'(expLevel), dataT'(highs));
		end
	endtask

	// ########################################################################
	// Reporting
	// ########################################################################

	task automatic endTest(input string name);
		testCount++;
		$display("test %s: %0d checks, %0d errors", name, testChecks, testErrs);
		testChecks = 0;
		testErrs = 0;
	endtask

	task automatic summary();
		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
	endtask

endmodule

`default_nettype wire

//--- testbench/apuSystemTb.sv
`timescale 1ns/10ps
`default_nettype none

module apuSystemTb
	import apuPkg::*;
;

	localparam int cycleLimit = 40000;

	logic clk;
	logic arstN;
	axiReqT req;
	axiRspT rsp;
	logic [7:0] pinIn;
	logic [7:0] pinOut;
	logic [7:0] pinOe;
	logic irqN;
	logic audio;
	levelT led;
	int cycles = 0;

	// Register model
	dataT mPulse0, mPulse1, mMaster;
	logic [7:0] mOut, mDir, mMask, mStat, mPin;

	apuSystem u_apuSystem (
		.clk, .arstN,
		.axiReq(req), .axiRsp(rsp),
		.pinIn, .pinOut, .pinOe,
		.irqN, .audio, .led
	);

	apuChecker apuChecker (.clk, .led, .audio, .pinOut, .pinOe, .irqN);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ########################################################################
	// Model
	// ########################################################################

	function automatic bit isWritable(input addrT a);
		return a inside {8'h00, 8'h04, 8'h08, 8'h0C, 8'h10, 8'h18, 8'h1C};
	endfunction

	function automatic dataT laneMerge(input dataT old, input dataT d, input logic [3:0] s);
		dataT r;
		r = old;
		for (int b = 0; b < 4; b++) begin
			if (s[b])
				r[8*b +: 8] = d[8*b +: 8];
		end
		return r;
	endfunction

	function automatic dataT modelRead(input addrT a);
		case (a)
			8'h00: return mPulse0;
			8'h04: return mPulse1;
			8'h08: return mMaster;
			8'h0C: return dataT'(mOut);
			8'h10: return dataT'(mDir);
			8'h14: return dataT'(mPin);
			8'h18: return dataT'(mStat);
			8'h1C: return dataT'(mMask);
			default: return '0;
		endcase
	endfunction

	// Period 10:0, duty 13:12, volume 19:16
	function automatic dataT pulseWord(input int period, input int duty, input int vol);
		return {12'd0, 4'(vol), 2'b00, 2'(duty), 1'b0, 11'(period)};
	endfunction

	// Amplitude a channel adds when its pattern bit is high
	function automatic int chanAmp(input dataT r);
		return (r[10:0] >= 11'd8) ? int'(r[19:16]) : 0;
	endfunction

	// ########################################################################
	// AXI driver
	// ########################################################################

	task automatic axiWrite(input addrT a, input dataT d, input logic [3:0] s,
		output logic [1:0] resp);
		int delay;
		logic seen;
		delay = $urandom % 4;
		seen = 1'b0;
		@(negedge clk);
		req.awvalid = 1'b1;
		req.awaddr = a;
		req.wvalid = 1'b1;
		req.wdata = d;
		req.wstrb = s;
		while (!seen) begin
			#1;
			seen = rsp.awready;
			@(negedge clk);
		end
		req.awvalid = 1'b0;
		req.wvalid = 1'b0;
		repeat (delay) @(negedge clk);
		req.bready = 1'b1;
		while (!rsp.bvalid)
			@(negedge clk);
		resp = rsp.bresp;
		@(negedge clk);
		req.bready = 1'b0;
	endtask

	task automatic axiRead(input addrT a, output dataT d, output logic [1:0] resp);
		int delay;
		logic seen;
		delay = $urandom % 4;
		seen = 1'b0;
		@(negedge clk);
		req.arvalid = 1'b1;
		req.araddr = a;
		while (!seen) begin
			#1;
			seen = rsp.arready;
			@(negedge clk);
		end
		req.arvalid = 1'b0;
		repeat (delay) @(negedge clk);
		req.rready = 1'b1;
		while (!rsp.rvalid)
			@(negedge clk);
		d = rsp.rdata;
		resp = rsp.rresp;
		@(negedge clk);
		req.rready = 1'b0;
	endtask

	task automatic regWrite(input addrT a, input dataT d, input logic [3:0] s);
		logic [1:0] resp;
		axiWrite(a, d, s, resp);
		apuChecker.checkEq("bresp", isWritable(a) ? 0 : 2, dataT'(resp));
		case (a)
			8'h00: mPulse0 = laneMerge(mPulse0, d, s) & 32'h000F_37FF;
			8'h04: mPulse1 = laneMerge(mPulse1, d, s) & 32'h000F_37FF;
			8'h08: mMaster = laneMerge(mMaster, d, s) & 32'h0000_010F;
			8'h0C: if (s[0]) mOut = d[7:0];
			8'h10: if (s[0]) mDir = d[7:0];
			8'h18: if (s[0]) mStat = mStat & ~d[7:0];
			8'h1C: if (s[0]) mMask = d[7:0];
			default: ;
		endcase
	endtask

	task automatic regRead(input addrT a);
		dataT d;
		logic [1:0] resp;
		axiRead(a, d, resp);
		apuChecker.checkEq($sformatf("rdata@%0h", a), modelRead(a), d);
		apuChecker.checkEq("rresp", (isWritable(a) || a == 8'h14) ? 0 : 2, dataT'(resp));
	endtask

	task automatic readAll();
		for (int a = 0; a < 32; a += 4)
			regRead(addrT'(a));
	endtask

	// ########################################################################
	// Tests
	// ########################################################################

	task automatic mixTest(input bit enable);
		int amp0;
		int amp1;
		regWrite(8'h00, pulseWord($urandom_range(63, 0), $urandom % 4, $urandom % 16), 4'hF);
		regWrite(8'h04, pulseWord($urandom_range(63, 0), $urandom % 4, $urandom % 16), 4'hF);
		regWrite(8'h08, {23'd0, enable, 4'd0, 4'($urandom % 16)}, 4'hF);
		amp0 = chanAmp(mPulse0);
		amp1 = chanAmp(mPulse1);
		repeat (2000) @(negedge clk);
		for (int i = 0; i < 600; i++) begin
			if (enable)
				apuChecker.checkLedSet(amp0, amp1, mMaster[3:0]);
			else
				apuChecker.checkEq("led", '0, dataT'(led));
			@(negedge clk);
		end
	endtask

	task automatic singleChannelTest();
		int peak;
		bit sawZero;
		bit sawPeak;
		sawZero = 0;
		sawPeak = 0;
		regWrite(8'h00, pulseWord($urandom_range(63, 8), $urandom % 4,
			$urandom_range(15, 2)), 4'hF);
		regWrite(8'h04, pulseWord(3, $urandom % 4, 15), 4'hF);
		regWrite(8'h08, {23'd0, 1'b1, 4'd0, 4'($urandom_range(15, 1))}, 4'hF);
		peak = chanAmp(mPulse0) * mMaster[3:0] / 2;
		repeat (2000) @(negedge clk);
		for (int i = 0; i < 600; i++) begin
			if (led == 0)
				sawZero = 1;
			if (led == peak)
				sawPeak = 1;
			apuChecker.checkLedSet(chanAmp(mPulse0), 0, mMaster[3:0]);
			@(negedge clk);
		end
		if (!sawZero || !sawPeak)
			apuChecker.failText("single channel did not show both silence and its peak level");
	endtask

	task automatic pwmTest();
		int good;
		int peak;
		bit ok;
		good = 0;
		// Slow duty 3 channel keeps led steady over many frames
		regWrite(8'h00, pulseWord(2047, 3, $urandom_range(15, 2)), 4'hF);
		regWrite(8'h04, pulseWord(3, 0, 0), 4'hF);
		regWrite(8'h08, {23'd0, 1'b1, 4'd0, 4'($urandom_range(15, 1))}, 4'hF);
		peak = chanAmp(mPulse0) * mMaster[3:0] / 2;
		while (good < 4) begin
			apuChecker.measureFrame(peak, ok);
			if (ok)
				good++;
		end
	endtask

	task automatic edgeTest();
		logic [7:0] prev;
		logic [7:0] pat;
		prev = pinIn;
		for (int i = 0; i < 20; i++) begin
			pat = $urandom;
			@(negedge clk);
			pinIn = pat;
			mStat = mStat | (pat & ~prev & ~mDir);
			prev = pat;
			repeat ($urandom % 3) @(negedge clk);
		end
		mPin = pinIn;
		repeat (5) @(negedge clk);
		regRead(8'h18);
		regRead(8'h14);
		apuChecker.checkIrq(mStat, mMask);
		regWrite(8'h18, dataT'($urandom % 256), 4'h1);
		regRead(8'h18);
		apuChecker.checkIrq(mStat, mMask);
	endtask

	initial begin
		addrT a;
		void'($urandom(51));
		arstN = 1'b0;
		req = '0;
		pinIn = '0;
		{mPulse0, mPulse1, mMaster} = '0;
		{mOut, mDir, mMask, mStat, mPin} = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;

		apuChecker.checkPins(8'h00, 8'h00);
		apuChecker.checkEq("led", '0, dataT'(led));
		apuChecker.checkEq("audio", '0, dataT'(audio));
		apuChecker.checkIrq(8'h00, 8'h00);
		readAll();
		apuChecker.endTest("reset");

		for (int i = 0; i < 200; i++) begin
			a = addrT'(4 * ($urandom % 8));
			if (a == 8'h14)
				a = 8'h1C;
			regWrite(a, $urandom, 4'($urandom % 16));
			regRead(a);
		end
		// Bad targets return an error and leave the map alone
		regWrite(8'h20, $urandom, 4'hF);
		regWrite(8'h02, $urandom, 4'hF);
		regWrite(8'h14, $urandom, 4'hF);
		regRead(8'h24);
		regRead(8'hFC);
		readAll();
		apuChecker.endTest("readback");

		for (int i = 0; i < 3; i++)
			mixTest(1'b1);
		mixTest(1'b0);
		singleChannelTest();
		apuChecker.endTest("mixing");

		pwmTest();
		apuChecker.endTest("pwm");

		for (int i = 0; i < 20; i++) begin
			regWrite(8'h0C, $urandom, 4'h1);
			regWrite(8'h10, $urandom, 4'h1);
			repeat (2) @(negedge clk);
			apuChecker.checkPins(mOut, mDir);
		end
		apuChecker.endTest("gpio");

		regWrite(8'h10, '0, 4'h1);
		regWrite(8'h18, 32'hFF, 4'h1);
		for (int i = 0; i < 5; i++) begin
			regWrite(8'h1C, $urandom, 4'h1);
			edgeTest();
		end
		apuChecker.endTest("interrupts");

		apuChecker.summary();
		if (apuChecker.errCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- apuSystem.f
logic/apuPkg.sv
logic/apuBusRegs.sv
logic/apuPulse.sv
logic/apuMixer.sv
logic/apuPwm.sv
logic/gpioPort.sv
logic/apuSystem.sv
testbench/apuChecker.sv
testbench/apuSystemTb.sv

//--- run.sh
#!/bin/bash
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f apuSystem.f --top-module apuSystemTb -o simApu \
	&& ./obj_dir/simApu | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null \
	&& echo "simulation run finished with a pass" \
	|| { echo "simulation run failed"; exit 1; }
